//--- lc4_pkg.sv
`default_nettype none

package lc4_pkg;

    localparam int WORD_W    = 16;
    localparam int REG_SEL_W = 3;
    localparam int NUM_REGS  = 8;

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [REG_SEL_W-1:0] reg_sel_t;
    // one-hot flags, n in bit 2 and p in bit 0
    typedef logic [2:0]           nzp_t;

    localparam word_t RESET_PC = 16'h8200;

    // insn[15:12]
    localparam logic [3:0] OPC_BR    = 4'b0000;
    localparam logic [3:0] OPC_ARITH = 4'b0001;
    localparam logic [3:0] OPC_LDR   = 4'b0110;
    localparam logic [3:0] OPC_STR   = 4'b0111;
    localparam logic [3:0] OPC_CONST = 4'b1001;

    // insn[5:3] of the arithmetic group
    localparam logic [2:0] SUB_ADD = 3'b000;
    localparam logic [2:0] SUB_SUB = 3'b010;

    typedef enum logic [1:0] {
        BYP_NONE,
        BYP_M,
        BYP_W
    } byp_sel_t;

    typedef struct packed {
        word_t    insn;
        reg_sel_t rs;
        reg_sel_t rt;
        reg_sel_t rd;
        logic     rs_re;
        logic     rt_re;
        logic     rd_we;
        logic     nzp_we;
        logic     is_load;
        logic     is_store;
        logic     is_branch;
    } ctl_t;

    typedef struct packed {
        ctl_t  ctl;
        word_t pc;
        word_t rs_val;
        word_t rt_val;
    } stage_t;

    typedef struct packed {
        logic  we;
        word_t addr;
        word_t wdata;
    } dmem_req_t;

    typedef struct packed {
        logic     we;
        reg_sel_t wsel;
        word_t    data;
    } wb_trace_t;

    // operand source picked by the hazard unit
    function automatic word_t byp_mux(input byp_sel_t sel, input word_t rf_val,
                                      input word_t m_val, input word_t w_val);
        case (sel)
            BYP_M:   return m_val;
            BYP_W:   return w_val;
            default: return rf_val;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- lc4_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module lc4_decoder (
    input  wire lc4_pkg::word_t i_insn,
    output lc4_pkg::ctl_t       o_ctl
);

    logic [3:0] opc;

    assign opc = i_insn[15:12];

    always_comb begin
        o_ctl      = '0;
        o_ctl.insn = i_insn;
        case (opc)
            lc4_pkg::OPC_BR: begin
                // BR with nzp 000 falls through as a no-op
                o_ctl.is_branch = |i_insn[11:9];
            end
            lc4_pkg::OPC_ARITH: begin
                // insn[5] set means ADD immediate, rt field is part of imm5
                if (i_insn[5] || i_insn[5:3] == lc4_pkg::SUB_ADD ||
                    i_insn[5:3] == lc4_pkg::SUB_SUB) begin
                    o_ctl.rd     = i_insn[11:9];
                    o_ctl.rs     = i_insn[8:6];
                    o_ctl.rt     = i_insn[2:0];
                    o_ctl.rs_re  = 1'b1;
                    o_ctl.rt_re  = ~i_insn[5];
                    o_ctl.rd_we  = 1'b1;
                    o_ctl.nzp_we = 1'b1;
                end
            end
            lc4_pkg::OPC_CONST: begin
                o_ctl.rd     = i_insn[11:9];
                o_ctl.rd_we  = 1'b1;
                o_ctl.nzp_we = 1'b1;
            end
            lc4_pkg::OPC_LDR: begin
                o_ctl.rd      = i_insn[11:9];
                o_ctl.rs      = i_insn[8:6];
                o_ctl.rs_re   = 1'b1;
                o_ctl.rd_we   = 1'b1;
                o_ctl.nzp_we  = 1'b1;
                o_ctl.is_load = 1'b1;
            end
            lc4_pkg::OPC_STR: begin
                // store data register sits in the rd slot of the encoding
                o_ctl.rt       = i_insn[11:9];
                o_ctl.rs       = i_insn[8:6];
                o_ctl.rs_re    = 1'b1;
                o_ctl.rt_re    = 1'b1;
                o_ctl.is_store = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- lc4_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module lc4_regfile (
    input  wire                     gwe,
    input  wire                     i_arst_n,
    input  wire lc4_pkg::reg_sel_t  i_rs,
    input  wire lc4_pkg::reg_sel_t  i_rt,
    output lc4_pkg::word_t          o_rs_data,
    output lc4_pkg::word_t          o_rt_data,
    input  wire lc4_pkg::wb_trace_t i_wb
);

    lc4_pkg::word_t regs [lc4_pkg::NUM_REGS];

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < lc4_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wb.we) begin
            regs[i_wb.wsel] <= i_wb.data;
        end
    end

    // same-cycle write is visible to decode
    assign o_rs_data = (i_wb.we && i_wb.wsel == i_rs) ? i_wb.data : regs[i_rs];
    assign o_rt_data = (i_wb.we && i_wb.wsel == i_rt) ? i_wb.data : regs[i_rt];

endmodule

`default_nettype wire

//--- lc4_hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module lc4_hazard_unit (
    input  wire lc4_pkg::ctl_t i_d,
    input  wire lc4_pkg::ctl_t i_x,
    input  wire lc4_pkg::ctl_t i_m,
    input  wire lc4_pkg::ctl_t i_w,
    input  wire                i_taken,
    output logic               o_stall,
    output logic               o_flush,
    output lc4_pkg::byp_sel_t  o_rs_sel,
    output lc4_pkg::byp_sel_t  o_rt_sel,
    output logic               o_st_byp
);

    logic ld_use;
    logic ld_br;

    // memory stage is the younger producer, a load there is not ready yet
    function automatic lc4_pkg::byp_sel_t pick(input logic re, input lc4_pkg::reg_sel_t sel,
                                               input lc4_pkg::ctl_t m,
                                               input lc4_pkg::ctl_t w);
        if (re && m.rd_we && !m.is_load && m.rd == sel) begin
            return lc4_pkg::BYP_M;
        end
        if (re && w.rd_we && w.rd == sel) begin
            return lc4_pkg::BYP_W;
        end
        return lc4_pkg::BYP_NONE;
    endfunction

    // store data can wait for the WM path, so only address and ALU operands stall
    assign ld_use = i_x.is_load && i_x.rd_we &&
                    ((i_d.rs_re && i_d.rs == i_x.rd) ||
                     (i_d.rt_re && !i_d.is_store && i_d.rt == i_x.rd));

    // branch flags from a load come from the data word, one cycle later
    assign ld_br = i_x.is_load && i_d.is_branch;

    assign o_stall = ld_use || ld_br;
    assign o_flush = i_taken;

    assign o_rs_sel = pick(i_x.rs_re, i_x.rs, i_m, i_w);
    assign o_rt_sel = pick(i_x.rt_re, i_x.rt, i_m, i_w);

    // late store data, typically a load right before the store
    assign o_st_byp = i_m.is_store && i_w.rd_we && i_w.rd == i_m.rt;

endmodule

`default_nettype wire

//--- lc4_execute.sv
`timescale 1ns/1ps
`default_nettype none

module lc4_execute (
    input  wire                    gwe,
    input  wire                    i_arst_n,
    input  wire lc4_pkg::stage_t   i_x,
    input  wire lc4_pkg::word_t    i_m_value,
    input  wire lc4_pkg::word_t    i_w_value,
    input  wire lc4_pkg::byp_sel_t i_rs_sel,
    input  wire lc4_pkg::byp_sel_t i_rt_sel,
    input  wire                    i_m_is_load,
    input  wire lc4_pkg::word_t    i_dmem_rdata,
    output lc4_pkg::word_t         o_result,
    output lc4_pkg::word_t         o_target,
    output logic                   o_taken
);

    lc4_pkg::word_t insn;
    lc4_pkg::word_t rs_val;
    lc4_pkg::word_t rt_val;
    lc4_pkg::word_t imm9;
    lc4_pkg::nzp_t  nzp_q;
    lc4_pkg::nzp_t  nzp_cur;

    function automatic lc4_pkg::nzp_t sign_of(input lc4_pkg::word_t v);
        if (v[lc4_pkg::WORD_W-1]) begin
            return 3'b100;
        end
        if (v == '0) begin
            return 3'b010;
        end
        return 3'b001;
    endfunction

    assign insn   = i_x.ctl.insn;
    assign imm9   = {{7{insn[8]}}, insn[8:0]};
    assign rs_val = lc4_pkg::byp_mux(i_rs_sel, i_x.rs_val, i_m_value, i_w_value);
    assign rt_val = lc4_pkg::byp_mux(i_rt_sel, i_x.rt_val, i_m_value, i_w_value);

    always_comb begin
        case (insn[15:12])
            lc4_pkg::OPC_ARITH: begin
                if (insn[5]) begin
                    o_result = rs_val + {{11{insn[4]}}, insn[4:0]};
                end else if (insn[5:3] == lc4_pkg::SUB_SUB) begin
                    o_result = rs_val - rt_val;
                end else begin
                    o_result = rs_val + rt_val;
                end
            end
            lc4_pkg::OPC_CONST: o_result = imm9;
            // address generation for LDR and STR
            lc4_pkg::OPC_LDR, lc4_pkg::OPC_STR: o_result = rs_val + {{10{insn[5]}}, insn[5:0]};
            default: o_result = '0;
        endcase
    end

    // a load just ahead has not updated the flags yet
    assign nzp_cur  = i_m_is_load ? sign_of(i_dmem_rdata) : nzp_q;
    assign o_target = i_x.pc + 16'd1 + imm9;
    assign o_taken  = i_x.ctl.is_branch && |(insn[11:9] & nzp_cur);

    // execute result is younger than a load in memory, so it wins
    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            nzp_q <= '0;
        end else if (i_x.ctl.nzp_we && !i_x.ctl.is_load) begin
            nzp_q <= sign_of(o_result);
        end else if (i_m_is_load) begin
            nzp_q <= sign_of(i_dmem_rdata);
        end
    end

endmodule

`default_nettype wire

//--- lc4_core.sv
`timescale 1ns/1ps
`default_nettype none

module lc4_core (
    input  wire                  gwe,
    input  wire                  i_arst_n,
    output lc4_pkg::word_t       o_imem_addr,
    input  wire lc4_pkg::word_t  i_imem_data,
    output lc4_pkg::dmem_req_t   o_dmem,
    input  wire lc4_pkg::word_t  i_dmem_rdata,
    output lc4_pkg::wb_trace_t   o_wb
);

    lc4_pkg::word_t    pc_q;
    lc4_pkg::word_t    pc_next;
    lc4_pkg::stage_t   d_q;
    lc4_pkg::stage_t   x_q;
    lc4_pkg::stage_t   m_q;
    lc4_pkg::stage_t   w_q;
    lc4_pkg::stage_t   d_next;
    lc4_pkg::stage_t   x_next;
    lc4_pkg::stage_t   m_next;
    lc4_pkg::stage_t   w_next;
    lc4_pkg::ctl_t     d_ctl;
    lc4_pkg::word_t    rs_data;
    lc4_pkg::word_t    rt_data;
    lc4_pkg::word_t    ex_result;
    lc4_pkg::word_t    ex_target;
    logic              ex_taken;
    logic              stall;
    logic              flush;
    logic              st_byp;
    lc4_pkg::byp_sel_t rs_sel;
    lc4_pkg::byp_sel_t rt_sel;
    lc4_pkg::word_t    w_value;

    // fetch
    assign o_imem_addr = pc_q;
    assign pc_next     = flush ? ex_target : (stall ? pc_q : pc_q + 16'd1);

    always_comb begin
        d_next          = '0;
        d_next.ctl.insn = i_imem_data;
        d_next.pc       = pc_q;
    end

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc_q <= lc4_pkg::RESET_PC;
            d_q  <= '0;
        end else begin
            pc_q <= pc_next;
            if (flush) begin
                d_q <= '0;
            end else if (!stall) begin
                d_q <= d_next;
            end
        end
    end

    // decode
    lc4_decoder u_decoder (
        .i_insn (d_q.ctl.insn),
        .o_ctl  (d_ctl)
    );

    lc4_regfile u_regfile (
        .gwe       (gwe),
        .i_arst_n  (i_arst_n),
        .i_rs      (d_ctl.rs),
        .i_rt      (d_ctl.rt),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data),
        .i_wb      (o_wb)
    );

    always_comb begin
        x_next.ctl    = d_ctl;
        x_next.pc     = d_q.pc;
        x_next.rs_val = rs_data;
        x_next.rt_val = rt_data;
    end

    lc4_hazard_unit u_hazard (
        .i_d      (d_ctl),
        .i_x      (x_q.ctl),
        .i_m      (m_q.ctl),
        .i_w      (w_q.ctl),
        .i_taken  (ex_taken),
        .o_stall  (stall),
        .o_flush  (flush),
        .o_rs_sel (rs_sel),
        .o_rt_sel (rt_sel),
        .o_st_byp (st_byp)
    );

    // execute
    lc4_execute u_execute (
        .gwe          (gwe),
        .i_arst_n     (i_arst_n),
        .i_x          (x_q),
        .i_m_value    (m_q.rs_val),
        .i_w_value    (w_value),
        .i_rs_sel     (rs_sel),
        .i_rt_sel     (rt_sel),
        .i_m_is_load  (m_q.ctl.is_load),
        .i_dmem_rdata (i_dmem_rdata),
        .o_result     (ex_result),
        .o_target     (ex_target),
        .o_taken      (ex_taken)
    );

    // from here on rs_val carries the ALU value or address, rt_val the store data
    always_comb begin
        m_next        = x_q;
        m_next.rs_val = ex_result;
        m_next.rt_val = lc4_pkg::byp_mux(rt_sel, x_q.rt_val, m_q.rs_val, w_value);
    end

    // writeback keeps both the ALU value and the load data
    always_comb begin
        w_next        = m_q;
        w_next.rt_val = i_dmem_rdata;
    end

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            x_q <= '0;
            m_q <= '0;
            w_q <= '0;
        end else begin
            // bubble on a stall, squash on a taken branch
            x_q <= (flush || stall) ? '0 : x_next;
            m_q <= m_next;
            w_q <= w_next;
        end
    end

    // memory
    always_comb begin
        o_dmem.we    = m_q.ctl.is_store;
        o_dmem.addr  = (m_q.ctl.is_load || m_q.ctl.is_store) ? m_q.rs_val : '0;
        o_dmem.wdata = st_byp ? w_value : m_q.rt_val;
    end

    // writeback
    assign w_value = w_q.ctl.is_load ? w_q.rt_val : w_q.rs_val;

    always_comb begin
        o_wb.we   = w_q.ctl.rd_we;
        o_wb.wsel = w_q.ctl.rd;
        o_wb.data = w_value;
    end

endmodule

`default_nettype wire

//--- tb_lc4_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lc4_core;

    localparam int PROG_LEN  = 20;
    localparam int NUM_WB    = 12;
    localparam int TIMEOUT   = PROG_LEN * 4 + 20;
    localparam int MEM_WORDS = 256;

    logic                gwe;
    logic                i_arst_n;
    lc4_pkg::word_t      i_imem_data;
    lc4_pkg::word_t      i_dmem_rdata;
    lc4_pkg::word_t      o_imem_addr;
    lc4_pkg::dmem_req_t  o_dmem;
    lc4_pkg::wb_trace_t  o_wb;

    lc4_pkg::word_t imem [MEM_WORDS];
    lc4_pkg::word_t dmem [MEM_WORDS];
    lc4_pkg::word_t fetch_off;
    int             cycles  = 0;
    int             exp_idx = 0;

    // program placed at RESET_PC, one word per entry
    lc4_pkg::word_t prog [PROG_LEN] = '{
        16'h9205,  // CONST R1, #5
        16'h1441,  // ADD   R2, R1, R1
        16'h1691,  // SUB   R3, R2, R1
        16'h18FD,  // ADD   R4, R3, #-3
        16'h780A,  // STR   R4, R0, #10
        16'h6A0A,  // LDR   R5, R0, #10
        16'h1D41,  // ADD   R6, R5, R1   load-use stall
        16'h1ED1,  // SUB   R7, R3, R1   zero result
        16'h0402,  // BRz   +2           taken
        16'h9263,  // CONST R1, #99      squashed
        16'h944D,  // CONST R2, #77      squashed
        16'h14A1,  // ADD   R2, R2, #1
        16'h0801,  // BRn   +1           not taken
        16'h16E2,  // ADD   R3, R3, #2
        16'h93FC,  // CONST R1, #-4
        16'h720B,  // STR   R1, R0, #11
        16'h680B,  // LDR   R4, R0, #11
        16'h0801,  // BRn   +1           taken on load flags
        16'h9A01,  // CONST R5, #1       squashed
        16'h1D06   // ADD   R6, R4, R6
    };

    // writebacks in program order as we, wsel, data
    lc4_pkg::wb_trace_t exp_wb [NUM_WB] = '{
        '{1'b1, 3'd1, 16'h0005},
        '{1'b1, 3'd2, 16'h000A},
        '{1'b1, 3'd3, 16'h0005},
        '{1'b1, 3'd4, 16'h0002},
        '{1'b1, 3'd5, 16'h0002},
        '{1'b1, 3'd6, 16'h0007},
        '{1'b1, 3'd7, 16'h0000},
        '{1'b1, 3'd2, 16'h000B},
        '{1'b1, 3'd3, 16'h0007},
        '{1'b1, 3'd1, 16'hFFFC},
        '{1'b1, 3'd4, 16'hFFFC},
        '{1'b1, 3'd6, 16'h0003}
    };

    lc4_core dut_i (
        .gwe          (gwe),
        .i_arst_n     (i_arst_n),
        .o_imem_addr  (o_imem_addr),
        .i_imem_data  (i_imem_data),
        .o_dmem       (o_dmem),
        .i_dmem_rdata (i_dmem_rdata),
        .o_wb         (o_wb)
    );

    task automatic abort_run();
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_bit(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            $display("ERR t=%0t %s got=%b exp=%b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_word(input lc4_pkg::word_t got, input lc4_pkg::word_t exp,
                              input string name);
        if (got !== exp) begin
            $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_wb(input lc4_pkg::wb_trace_t got, input lc4_pkg::wb_trace_t exp,
                            input string name);
        if (got !== exp) begin
            $display("ERR t=%0t %s got we=%b wsel=%0d data=%h exp we=%b wsel=%0d data=%h",
                     $time, name, got.we, got.wsel, got.data, exp.we, exp.wsel, exp.data);
            abort_run();
        end
    endtask

    initial begin
        gwe = 1'b0;
        forever #2 gwe = ~gwe;
    end

    // memory models, updated mid-cycle so the core sees stable data at the next edge
    initial begin
        i_imem_data  = '0;
        i_dmem_rdata = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            if (i < PROG_LEN) begin
                imem[i] = prog[i];
            end else begin
                imem[i] = '0;
            end
            dmem[i] = '0;
        end
        forever begin
            @(negedge gwe);
            if (o_dmem.we) begin
                dmem[o_dmem.addr[7:0]] = o_dmem.wdata;
            end
            fetch_off    = o_imem_addr - lc4_pkg::RESET_PC;
            // zero outside the program window decodes as a no-op
            i_imem_data  = (fetch_off < 16'd256) ? imem[fetch_off[7:0]] : '0;
            i_dmem_rdata = dmem[o_dmem.addr[7:0]];
        end
    end

    // writeback monitor
    always @(negedge gwe) begin
        if (cycles < 4) begin
            check_bit(o_wb.we, 1'b0, "o_wb.we");
            check_bit(o_dmem.we, 1'b0, "o_dmem.we");
        end else if (cycles == 4) begin
            // first fetch after reset retires four cycles later
            check_bit(o_wb.we, 1'b1, "o_wb.we");
        end
        if (o_wb.we) begin
            if (exp_idx >= NUM_WB) begin
                $display("extra writeback to R%0d seen after the expected list ended",
                         o_wb.wsel);
                abort_run();
            end else begin
                check_wb(o_wb, exp_wb[exp_idx], "o_wb");
                exp_idx++;
            end
        end
    end

    initial begin
        i_arst_n = 1'b0;
        repeat (2) @(negedge gwe);
        check_word(o_imem_addr, lc4_pkg::RESET_PC, "o_imem_addr");
        i_arst_n = 1'b1;
        while (exp_idx < NUM_WB && cycles < TIMEOUT) begin
            @(posedge gwe);
            cycles++;
        end
        if (exp_idx < NUM_WB) begin
            $display("timeout after %0d cycles with %0d of %0d writebacks seen",
                     cycles, exp_idx, NUM_WB);
            abort_run();
        end else begin
            // let any stray writeback show up before the final checks
            repeat (6) @(negedge gwe);
            check_word(dmem[10], 16'h0002, "dmem[10]");
            check_word(dmem[11], 16'hFFFC, "dmem[11]");
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- filelist.f
lc4_pkg.sv
lc4_decoder.sv
lc4_regfile.sv
lc4_hazard_unit.sv
lc4_execute.sv
lc4_core.sv
tb_lc4_core.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the LC4 pipeline testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module tb_lc4_core -f filelist.f &&
./obj_dir/Vtb_lc4_core | tee /dev/stderr | grep -qF "=== PASS ===" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
